/* logic/memSysPkg.sv */
`default_nettype none

package memSysPkg;

  // Cache geometry, shared by both caches
  localparam int BlockWords = 4;
  localparam int CacheLines = 16;

  // Memory model size in 32-bit words
  localparam int MemWords   = 4096;
  // Wait states from a presented request to its ready pulse
  localparam int MemLatency = 2;

  // Address field widths
  localparam int ByteBits   = 2;
  localparam int WordBits   = $clog2(BlockWords);
  localparam int IndexBits  = $clog2(CacheLines);
  localparam int MemIdxBits = $clog2(MemWords);
  // Byte address bits the memory actually decodes
  localparam int AddrBits   = MemIdxBits + ByteBits;
  // Tag covers what is left of the decoded address
  localparam int TagBits    = AddrBits - IndexBits - WordBits - ByteBits;
  localparam int BlockLsb   = ByteBits + WordBits;
  localparam int TagLsb     = BlockLsb + IndexBits;
  localparam int LatCntBits = $clog2(MemLatency + 1);

  // Cache controller states, the instruction side skips WriteBack
  typedef enum logic [1:0] {Idle, WriteBack, Fill} cacheStateT;

  // Current owner of the shared bus
  typedef enum logic {OwnerInstr, OwnerData} busOwnerT;

  // Request side of the word bus, request is a level
  typedef struct packed {
    logic        request;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wData;
  } busReqT;

  // Response side, ready is a one-cycle pulse
  typedef struct packed {
    logic        ready;
    logic [31:0] rData;
  } busRspT;

endpackage

`default_nettype wire

/* logic/instrCache.sv */
`timescale 1ns/100ps
`default_nettype none

module instrCache import memSysPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] pcF,
  input  busRspT      busRsp,
  output logic [31:0] instrF,
  output logic        iStall,
  output busReqT      busReq
);

  // Per-line tag and valid, plus the block store
  logic [TagBits-1:0]    tagArr   [CacheLines];
  logic [CacheLines-1:0] validArr;
  logic [31:0]           blockArr [CacheLines][BlockWords];

  cacheStateT          state;
  logic [WordBits-1:0] wordCnt;
  // Core starts fetching one cycle after reset release
  logic                fetchOn;

  logic [IndexBits-1:0] lineIdx;
  logic [WordBits-1:0]  wordSel;
  logic [TagBits-1:0]   pcTag;
  logic                 hit;
  logic                 lastWord;
  logic                 fillBeat;

  // Split the fetch address
  assign lineIdx = pcF[BlockLsb +: IndexBits];
  assign wordSel = pcF[ByteBits +: WordBits];
  assign pcTag   = pcF[TagLsb +: TagBits];

  assign hit      = validArr[lineIdx] && (tagArr[lineIdx] == pcTag);
  assign lastWord = (wordCnt == WordBits'(BlockWords - 1));
  // One refill word arrives
  assign fillBeat = (state == Fill) && busRsp.ready;

  // Hit data straight out of the block store
  assign instrF = blockArr[lineIdx][wordSel];
  // Stall rises in the miss cycle itself
  assign iStall = fetchOn && !hit;

  // Read-only bus request, held for the whole refill
  always_comb begin
    busReq         = '0;
    busReq.request = (state == Fill);
    // pcF is held by the core, so the block base comes from it
    busReq.addr    = {pcF[31:BlockLsb], wordCnt, {ByteBits{1'b0}}};
  end

  // Controller
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= Idle;
      wordCnt  <= '0;
      validArr <= '0;
      fetchOn  <= 1'b0;
    end else begin
      fetchOn <= 1'b1;
      case (state)
        Idle: begin
          if (iStall) begin
            // Line gets overwritten, drop it until the refill ends
            validArr[lineIdx] <= 1'b0;
            wordCnt           <= '0;
            state             <= Fill;
          end
        end
        Fill: begin
          if (busRsp.ready) begin
            // Step to the next word after each ready
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) begin
              validArr[lineIdx] <= 1'b1;
              state             <= Idle;
            end
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  // Refill words land in the block store, tag set with the last one
  always_ff @(posedge clk) begin
    if (fillBeat) begin
      blockArr[lineIdx][wordCnt] <= busRsp.rData;
      if (lastWord) begin
        tagArr[lineIdx] <= pcTag;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/dataCache.sv */
`timescale 1ns/100ps
`default_nettype none

module dataCache import memSysPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] dataAdrM,
  input  logic [31:0] writeDataM,
  input  logic [3:0]  byteMaskM,
  input  logic        memWriteM,
  input  logic        memToRegM,
  input  busRspT      busRsp,
  output logic [31:0] readDataM,
  output logic        dStall,
  output busReqT      busReq
);

  // Per-line tag, valid and dirty, plus the block store
  logic [TagBits-1:0]    tagArr   [CacheLines];
  logic [CacheLines-1:0] validArr;
  logic [CacheLines-1:0] dirtyArr;
  logic [31:0]           blockArr [CacheLines][BlockWords];

  cacheStateT          state;
  logic [WordBits-1:0] wordCnt;

  logic [IndexBits-1:0] lineIdx;
  logic [WordBits-1:0]  wordSel;
  logic [TagBits-1:0]   adrTag;
  logic                 access;
  logic                 hit;
  logic                 writeHit;
  logic                 lastWord;
  logic                 fillBeat;
  logic [31:0]          mergedWord;
  logic [31:0]          wbAddr;
  logic [31:0]          fillAddr;

  // Split the data address
  assign lineIdx = dataAdrM[BlockLsb +: IndexBits];
  assign wordSel = dataAdrM[ByteBits +: WordBits];
  assign adrTag  = dataAdrM[TagLsb +: TagBits];

  // Loads and stores both count as an access
  assign access   = memWriteM || memToRegM;
  assign hit      = validArr[lineIdx] && (tagArr[lineIdx] == adrTag);
  assign writeHit = (state == Idle) && memWriteM && hit;
  assign lastWord = (wordCnt == WordBits'(BlockWords - 1));
  assign fillBeat = (state == Fill) && busRsp.ready;

  // Read hit is combinational
  assign readDataM = blockArr[lineIdx][wordSel];
  // Stall stays up until the line holds the right tag
  assign dStall    = access && !hit;

  // Byte lanes picked by the mask replace the cached word
  always_comb begin
    mergedWord = readDataM;
    for (int b = 0; b < 4; b++) begin
      if (byteMaskM[b]) begin
        mergedWord[8*b +: 8] = writeDataM[8*b +: 8];
      end
    end
  end

  // Victim block address rebuilt from the stored tag
  assign wbAddr   = {{(32 - AddrBits){1'b0}}, tagArr[lineIdx], lineIdx, wordCnt,
                     {ByteBits{1'b0}}};
  // New block address from the held core address
  assign fillAddr = {dataAdrM[31:BlockLsb], wordCnt, {ByteBits{1'b0}}};

  // Request held high across write-back and fill
  always_comb begin
    busReq         = '0;
    busReq.request = (state != Idle);
    busReq.write   = (state == WriteBack);
    busReq.addr    = (state == WriteBack) ? wbAddr : fillAddr;
    busReq.wData   = blockArr[lineIdx][wordCnt];
  end

  // Controller
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= Idle;
      wordCnt  <= '0;
      validArr <= '0;
      dirtyArr <= '0;
    end else begin
      case (state)
        Idle: begin
          if (dStall) begin
            wordCnt <= '0;
            if (validArr[lineIdx] && dirtyArr[lineIdx]) begin
              // Dirty victim goes out first
              state <= WriteBack;
            end else begin
              validArr[lineIdx] <= 1'b0;
              dirtyArr[lineIdx] <= 1'b0;
              state             <= Fill;
            end
          end else if (writeHit) begin
            dirtyArr[lineIdx] <= 1'b1;
          end
        end
        WriteBack: begin
          if (busRsp.ready) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) begin
              // Victim is in memory now, refill follows without a gap
              validArr[lineIdx] <= 1'b0;
              dirtyArr[lineIdx] <= 1'b0;
              state             <= Fill;
            end
          end
        end
        Fill: begin
          if (busRsp.ready) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) begin
              validArr[lineIdx] <= 1'b1;
              state             <= Idle;
            end
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  // Block store takes refill words and store hits
  always_ff @(posedge clk) begin
    if (fillBeat) begin
      blockArr[lineIdx][wordCnt] <= busRsp.rData;
      if (lastWord) begin
        tagArr[lineIdx] <= adrTag;
      end
    end else if (writeHit) begin
      blockArr[lineIdx][wordSel] <= mergedWord;
    end
  end

endmodule

`default_nettype wire

/* logic/busArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module busArbiter import memSysPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  busReqT instrReq,
  input  busReqT dataReq,
  input  busRspT memRsp,
  output busReqT memReq,
  output busRspT instrRsp,
  output busRspT dataRsp
);

  busOwnerT owner;
  busOwnerT grantOwner;
  logic     busy;
  logic     ownerHolds;

  // Current owner keeps the bus while its request stays up
  assign ownerHolds = busy &&
                      ((owner == OwnerData) ? dataReq.request : instrReq.request);

  // Free bus goes to the data side first
  always_comb begin
    if (ownerHolds) begin
      grantOwner = owner;
    end else if (dataReq.request) begin
      grantOwner = OwnerData;
    end else begin
      grantOwner = OwnerInstr;
    end
  end

  // Forward the granted request
  assign memReq = (grantOwner == OwnerData) ? dataReq : instrReq;

  // Read data to both, ready only to the owner
  always_comb begin
    instrRsp       = memRsp;
    dataRsp        = memRsp;
    instrRsp.ready = memRsp.ready && (grantOwner == OwnerInstr);
    dataRsp.ready  = memRsp.ready && (grantOwner == OwnerData);
  end

  // Grant lock
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      owner <= OwnerData;
      busy  <= 1'b0;
    end else begin
      owner <= grantOwner;
      busy  <= memReq.request;
    end
  end

endmodule

`default_nettype wire

/* logic/busMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module busMemory import memSysPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  busReqT memReq,
  output busRspT memRsp
);

  typedef logic [31:0] memArrT [MemWords];

  // Every word starts out holding its own byte address
  function automatic memArrT fillPattern();
    memArrT pattern;
    for (int i = 0; i < MemWords; i++) begin
      pattern[i] = 32'(i * 4);
    end
    return pattern;
  endfunction

  memArrT memArr = fillPattern();

  logic [LatCntBits-1:0] waitCnt;
  logic [MemIdxBits-1:0] wordIdx;
  logic                  ready;

  // Word index wraps at the memory size
  assign wordIdx = memReq.addr[ByteBits +: MemIdxBits];

  // Ready once the request has waited out the latency
  assign ready = memReq.request && (waitCnt == LatCntBits'(MemLatency));

  always_comb begin
    memRsp       = '0;
    memRsp.ready = ready;
    memRsp.rData = memArr[wordIdx];
  end

  // Wait-state counter, restarts after each ready
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      waitCnt <= '0;
    end else if (!memReq.request || ready) begin
      waitCnt <= '0;
    end else begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // Store happens on the ready pulse
  always_ff @(posedge clk) begin
    if (ready && memReq.write) begin
      memArr[wordIdx] <= memReq.wData;
    end
  end

endmodule

`default_nettype wire

/* logic/memSystem.sv */
`timescale 1ns/100ps
`default_nettype none

module memSystem import memSysPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] pcF,
  input  logic [31:0] dataAdrM,
  input  logic [31:0] writeDataM,
  input  logic [3:0]  byteMaskM,
  input  logic        memWriteM,
  input  logic        memToRegM,
  output logic [31:0] instrF,
  output logic        iStall,
  output logic [31:0] readDataM,
  output logic        dStall
);

  // Cache side of the arbiter
  busReqT instrReq;
  busReqT dataReq;
  busRspT instrRsp;
  busRspT dataRsp;
  // Memory side of the arbiter
  busReqT memReq;
  busRspT memRsp;

  // Fetch port
  instrCache i_instrCache (
    .clk(clk), .rstN(rstN), .pcF(pcF), .busRsp(instrRsp),
    .instrF(instrF), .iStall(iStall), .busReq(instrReq)
  );

  // Memory-stage port
  dataCache i_dataCache (
    .clk(clk), .rstN(rstN), .dataAdrM(dataAdrM), .writeDataM(writeDataM),
    .byteMaskM(byteMaskM), .memWriteM(memWriteM), .memToRegM(memToRegM),
    .busRsp(dataRsp), .readDataM(readDataM), .dStall(dStall), .busReq(dataReq)
  );

  // One owner per block transfer
  busArbiter i_busArbiter (
    .clk(clk), .rstN(rstN), .instrReq(instrReq), .dataReq(dataReq),
    .memRsp(memRsp), .memReq(memReq), .instrRsp(instrRsp), .dataRsp(dataRsp)
  );

  // Shared word memory with fixed wait states
  busMemory i_busMemory (
    .clk(clk), .rstN(rstN), .memReq(memReq), .memRsp(memRsp)
  );

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Reset low for 10 rising edges, released just after the last one
  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/memSystemTb.sv */
`timescale 1ns/100ps
`default_nettype none

module memSystemTb import memSysPkg::*; ();

  typedef enum logic [1:0] {OpFetch, OpLoad, OpStore, OpDual} stepOpT;
  typedef enum logic {ExpHit, ExpMiss} stallExpT;

  // Table row whose fetchAddr serves fetch and dual steps
  typedef struct packed {
    stepOpT      op;
    logic [31:0] dataAddr;
    logic [31:0] fetchAddr;
    logic [3:0]  mask;
    logic [31:0] data;
    stallExpT    stallExp;
  } stepT;

  logic        clk;
  logic        rstN;
  logic [31:0] pcF;
  logic [31:0] dataAdrM;
  logic [31:0] writeDataM;
  logic [3:0]  byteMaskM;
  logic        memWriteM;
  logic        memToRegM;
  logic [31:0] instrF;
  logic        iStall;
  logic [31:0] readDataM;
  logic        dStall;

  stepT        stepQ [$];
  logic [31:0] shadowMem [MemWords];
  logic [31:0] lfsrState;
  logic        tableReady = 1'b0;
  int          errorCount;
  int          passCount;
  int          failCount;

  clockGen i_clockGen (.clk(clk), .rstN(rstN));

  memSystem i_memSystem (
    .clk(clk), .rstN(rstN), .pcF(pcF), .dataAdrM(dataAdrM), .writeDataM(writeDataM),
    .byteMaskM(byteMaskM), .memWriteM(memWriteM), .memToRegM(memToRegM),
    .instrF(instrF), .iStall(iStall), .readDataM(readDataM), .dStall(dStall)
  );

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic randomWord(output logic [31:0] value);
    value = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  // Word index wraps at the memory size as in the bus memory
  function automatic logic [31:0] shadowRead(input logic [31:0] addr);
    return shadowMem[(addr >> 2) % MemWords];
  endfunction

  task automatic shadowWrite(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
    int idx;
    idx = (addr >> 2) % MemWords;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        shadowMem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] observed,
                            input logic [31:0] expected);
    if (observed !== expected) begin
      $display("FAIL %s: observed 0x%08h expected 0x%08h", name, observed, expected);
      errorCount++;
    end
  endtask

  function automatic stepT makeStep(input stepOpT op, input logic [31:0] dataAddr,
                                    input logic [31:0] fetchAddr, input logic [3:0] mask,
                                    input logic [31:0] data, input stallExpT stallExp);
    stepT s;
    s.op        = op;
    s.dataAddr  = dataAddr;
    s.fetchAddr = fetchAddr;
    s.mask      = mask;
    s.data      = data;
    s.stallExp  = stallExp;
    return s;
  endfunction

  function automatic string opName(input stepOpT op);
    case (op)
      OpFetch: return "fetch";
      OpLoad:  return "load";
      OpStore: return "store";
      default: return "fetch+load";
    endcase
  endfunction

  // 16-byte lines with the index in addr[7:4] and the tag from bit 8
  task automatic buildTable();
    // Fetch miss and then hits in the same block
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h200, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h208, 4'h0, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h20C, 4'h0, 32'h0, ExpHit));
    // Load miss and then hits in the same block
    stepQ.push_back(makeStep(OpLoad, 32'h340, 32'h0, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'h344, 32'h0, 4'h0, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpLoad, 32'h34C, 32'h0, 4'h0, 32'h0, ExpHit));
    // Store hits with mixed masks and random data where the field is zero
    stepQ.push_back(makeStep(OpStore, 32'h340, 32'h0, 4'hF, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpStore, 32'h344, 32'h0, 4'h1, 32'hA5A5_A5A5, ExpHit));
    stepQ.push_back(makeStep(OpStore, 32'h344, 32'h0, 4'hC, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpStore, 32'h348, 32'h0, 4'h6, 32'h1234_5678, ExpHit));
    stepQ.push_back(makeStep(OpLoad, 32'h340, 32'h0, 4'h0, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpLoad, 32'h344, 32'h0, 4'h0, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpLoad, 32'h348, 32'h0, 4'h0, 32'h0, ExpHit));
    // Write-allocate on a store miss
    stepQ.push_back(makeStep(OpStore, 32'h450, 32'h0, 4'hA, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'h450, 32'h0, 4'h0, 32'h0, ExpHit));
    stepQ.push_back(makeStep(OpLoad, 32'h454, 32'h0, 4'h0, 32'h0, ExpHit));
    // Dirty victim in line 6 goes back before the conflicting fill
    stepQ.push_back(makeStep(OpStore, 32'h560, 32'h0, 4'hF, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'h660, 32'h0, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'h560, 32'h0, 4'h0, 32'h0, ExpMiss));
    // Same for the merged line 4
    stepQ.push_back(makeStep(OpLoad, 32'h740, 32'h0, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'h344, 32'h0, 4'h0, 32'h0, ExpMiss));
    // Both sides miss in the same cycle
    stepQ.push_back(makeStep(OpDual, 32'h880, 32'h990, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpStore, 32'hAA0, 32'h0, 4'h3, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpDual, 32'hBA0, 32'hCB0, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpLoad, 32'hAA0, 32'h0, 4'h0, 32'h0, ExpMiss));
    // Fetches see stores that were evicted to memory
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h560, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h344, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'hAA0, 4'h0, 32'h0, ExpMiss));
    stepQ.push_back(makeStep(OpFetch, 32'h0, 32'h564, 4'h0, 32'h0, ExpHit));
  endtask

  // Core side drive a small delay after the rising edge
  task automatic applyStep(input stepT s, input logic [31:0] storeData);
    if (s.op == OpFetch || s.op == OpDual) begin
      pcF = s.fetchAddr;
    end
    if (s.op != OpFetch) begin
      dataAdrM = s.dataAddr;
    end
    writeDataM = storeData;
    byteMaskM  = s.mask;
    memWriteM  = (s.op == OpStore);
    memToRegM  = (s.op == OpLoad) || (s.op == OpDual);
  endtask

  initial begin
    stepT        s;
    logic [31:0] storeData;
    logic        waitI;
    logic        waitD;
    logic        sawI;
    logic        sawD;
    int          errsBefore;
    int          cycles;
    pcF        = '0;
    dataAdrM   = '0;
    writeDataM = '0;
    byteMaskM  = '0;
    memWriteM  = 1'b0;
    memToRegM  = 1'b0;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    lfsrState  = 32'd96265;
    // Every word holds its own byte address
    for (int i = 0; i < MemWords; i++) begin
      shadowMem[i] = 32'(i * 4);
    end
    buildTable();
    tableReady = 1'b1;

    // Both stalls quiet right after reset release
    wait (rstN === 1'b1);
    checkValue("iStall", iStall, 32'h0);
    checkValue("dStall", dStall, 32'h0);
    if (errorCount == 0) begin
      passCount++;
      $display("test reset: ok");
    end else begin
      failCount++;
      $display("test reset: mismatch");
    end

    foreach (stepQ[i]) begin
      s          = stepQ[i];
      errsBefore = errorCount;
      storeData  = s.data;
      if (s.op == OpStore && s.data == 32'h0) begin
        randomWord(storeData);
      end
      @(posedge clk);
      #1;
      applyStep(s, storeData);
      waitI  = (s.op == OpFetch) || (s.op == OpDual);
      waitD  = (s.op != OpFetch);
      sawI   = 1'b0;
      sawD   = 1'b0;
      cycles = 0;
      // Outputs are sampled at the falling edge and the access ends at the next rise
      do begin
        @(negedge clk);
        cycles++;
        if (iStall) begin
          sawI = 1'b1;
        end
        if (dStall) begin
          sawD = 1'b1;
        end
      end while ((waitI && iStall) || (waitD && dStall));

      if (waitI) begin
        checkValue("instrF", instrF, shadowRead(s.fetchAddr));
        checkValue("iStall seen", sawI, s.stallExp == ExpMiss);
      end
      if (waitD) begin
        if (s.op != OpStore) begin
          checkValue("readDataM", readDataM, shadowRead(s.dataAddr));
        end
        checkValue("dStall seen", sawD, s.stallExp == ExpMiss);
      end
      if (s.op == OpStore) begin
        shadowWrite(s.dataAddr, storeData, s.mask);
      end

      if (errorCount == errsBefore) begin
        passCount++;
      end else begin
        failCount++;
      end
      $display("test %0d %s data 0x%08h fetch 0x%08h: %s, %0d cycles", i, opName(s.op),
               s.dataAddr, s.fetchAddr, (errorCount == errsBefore) ? "ok" : "mismatch",
               cycles);
    end

    @(posedge clk);
    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             passCount + failCount, passCount, failCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog allows two block transfers per step plus reset and margin
  initial begin
    int limitCycles;
    wait (tableReady);
    limitCycles = stepQ.size() * 2 * BlockWords * (MemLatency + 2) + 10 + 200;
    repeat (limitCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles, a stall never cleared",
             limitCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/memSysPkg.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/busMemory.sv
logic/memSystem.sv
dv/clockGen.sv
dv/memSystemTb.sv
